//--- design/sdCard_consts.svh
`ifndef SDCARD_CONSTS_SVH
`define SDCARD_CONSTS_SVH

// Frame and block sizes
`define FRAME_BITS      48
`define BLOCK_NIBBLES   1024

// Command indices
`define CMD_0           6'd0
`define CMD_3           6'd3
`define CMD_7           6'd7
`define CMD_8           6'd8
`define CMD_12          6'd12
`define CMD_25          6'd25
`define CMD_55          6'd55
`define ACMD_23         6'd23
`define ACMD_41         6'd41
`define R3_INDEX        6'd63

// CRC polynomials, top term implied
`define CRC7_POLY       7'h09
`define CRC16_POLY      16'h1021

// Card address and status words
`define CARD_RCA        16'hAAAA
`define STATUS_R6       16'h0520
`define STATUS_STBY     32'h00000700
`define STATUS_APP      32'h00000120
`define STATUS_TRAN     32'h00000900
`define OCR_READY       32'hC1FF8080

// Write path tokens and timing in SD clocks
`define TOKEN_OK        5'b00101
`define TOKEN_BAD       5'b01011
`define RESP_DELAY      8
`define TOKEN_GAP       2
`define BUSY_CYCLES     4

`endif

//--- design/sdCardPkg.sv
`default_nettype none

package sdCardPkg;

    // =========================================================================
    // Bus and CRC primitives
    // =========================================================================
    typedef logic [5:0]  cmdIndexT;
    typedef logic [6:0]  crc7T;
    typedef logic [15:0] crc16T;

    // One sample of DAT[3:0]
    typedef logic [3:0]  datNibbleT;

    // =========================================================================
    // Command and response payloads
    // =========================================================================

    // Host command after framing checks
    typedef struct packed {
        cmdIndexT    index;
        logic [31:0] arg;
    } sdCmdT;

    // Card response before framing
    // noCrc sends the CRC field as all ones, as R3 does
    typedef struct packed {
        cmdIndexT    index;
        logic [31:0] arg;
        logic        noCrc;
    } sdRespT;

endpackage

`default_nettype wire

//--- design/serialCrc.sv
`timescale 1ns/1ps
`default_nettype none

module serialCrc #(
    parameter type crcT = logic [6:0],
    parameter crcT poly = '0
) (
    input  wire  clk,
    input  wire  rst_,
    input  wire  clear,
    input  wire  enable,
    input  wire  din,
    output crcT  crc,
    output crcT  crcNext
);

    localparam int Width = $bits(crcT);

    logic feedback;

    // Shift left, fold the polynomial in when feedback is set
    assign feedback = din ^ crc[Width-1];
    assign crcNext  = {crc[Width-2:0], 1'b0} ^ (feedback ? poly : crcT'(0));

    always_ff @(posedge clk) begin
        if (!rst_) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= crcNext;
        end
    end

endmodule

`default_nettype wire

//--- design/cmdReceiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdCard_consts.svh"

module cmdReceiver (
    input  wire               clk,
    input  wire               rst_,
    input  wire               cmdIn,
    output logic              cmdValid,
    output sdCardPkg::sdCmdT  cmd
);

    import sdCardPkg::*;

    // Start, transmission, index and argument are covered by the CRC
    localparam int CrcBits = `FRAME_BITS - 8;

    logic                    busy;
    logic [5:0]              bitCnt;
    logic [`FRAME_BITS-2:0]  shiftReg;
    logic [`FRAME_BITS-1:0]  frame;
    logic                    startBit;
    logic                    lastBit;
    logic                    crcEn;
    logic                    frameOk;
    crc7T                    crc;

    assign startBit = !busy && !cmdIn;
    assign lastBit  = busy && (bitCnt == 6'(`FRAME_BITS - 1));
    assign crcEn    = startBit || (busy && (bitCnt < 6'(CrcBits)));

    // Complete frame in the cycle the end bit is on the line
    assign frame = {shiftReg, cmdIn};

    assign frameOk = frame[`FRAME_BITS-2]
                  && (frame[7:1] == crc)
                  && frame[0];

    // Cleared on the end bit so that the next frame starts from zero
    serialCrc #(
        .crcT (crc7T),
        .poly (`CRC7_POLY)
    ) crc7 (
        .clk     (clk),
        .rst_    (rst_),
        .clear   (lastBit),
        .enable  (crcEn),
        .din     (cmdIn),
        .crc     (crc),
        .crcNext ()
    );

    // =========================================================================
    // Frame counter and strobe
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            busy     <= 1'b0;
            bitCnt   <= '0;
            cmdValid <= 1'b0;
        end else begin
            cmdValid <= lastBit && frameOk;
            if (startBit) begin
                busy   <= 1'b1;
                bitCnt <= 6'd1;
            end else if (busy) begin
                bitCnt <= bitCnt + 6'd1;
                if (lastBit) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startBit || busy) begin
            shiftReg <= {shiftReg[`FRAME_BITS-3:0], cmdIn};
        end
        if (lastBit) begin
            cmd.index <= frame[45:40];
            cmd.arg   <= frame[39:8];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_) cmdValid |=> !cmdValid);

endmodule

`default_nettype wire

//--- design/cmdResponder.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdCard_consts.svh"

module cmdResponder (
    input  wire               clk,
    input  wire               rst_,
    input  wire               cmdValid,
    input  wire sdCardPkg::sdCmdT cmd,
    output logic              cmdOut,
    output logic              cmdOe,
    output logic              writeMode,
    output logic              respDone
);

    import sdCardPkg::*;

    localparam int CrcStart = `FRAME_BITS - 8;
    localparam int DelayW   = $clog2(`RESP_DELAY);

    typedef enum logic [1:0] {stIdle, stDelay, stSend} stateT;

    stateT                   state;
    logic                    acmd;
    logic                    accept;
    logic                    respond;
    logic                    start;
    sdRespT                  resp;
    logic [`FRAME_BITS-1:0]  txReg;
    logic                    noCrcReg;
    logic [5:0]              txCnt;
    logic [DelayW-1:0]       delayCnt;
    logic                    crcEn;
    crc7T                    crcNext;
    crc7T                    crcField;

    // =========================================================================
    // Command decode
    // =========================================================================
    always_comb begin
        accept  = 1'b1;
        respond = 1'b1;
        resp    = '{index: cmd.index, arg: 32'h0, noCrc: 1'b0};
        if (acmd && cmd.index == `ACMD_23) begin
            // Block count must be nonzero
            accept   = (cmd.arg[22:0] != 23'h0);
            resp.arg = `STATUS_TRAN;
        end else if (acmd && cmd.index == `ACMD_41) begin
            resp = '{index: `R3_INDEX, arg: `OCR_READY, noCrc: 1'b1};
        end else begin
            case (cmd.index)
                `CMD_0:  respond = 1'b0;
                `CMD_3:  resp.arg = {`CARD_RCA, `STATUS_R6};
                `CMD_7: begin
                    accept   = (cmd.arg[31:16] == `CARD_RCA);
                    resp.arg = `STATUS_STBY;
                end
                `CMD_8:  resp.arg = {20'h0, cmd.arg[11:0]};
                `CMD_12: resp.arg = `STATUS_TRAN;
                `CMD_25: resp.arg = `STATUS_TRAN;
                `CMD_55: resp.arg = `STATUS_APP;
                default: accept = 1'b0;
            endcase
        end
    end

    assign start    = cmdValid && accept && respond;
    assign crcEn    = (state == stSend) && (txCnt < 6'(CrcStart));
    assign crcField = noCrcReg ? '1 : crcNext;
    assign cmdOut   = cmdOe ? txReg[`FRAME_BITS-1] : 1'b1;

    serialCrc #(
        .crcT (crc7T),
        .poly (`CRC7_POLY)
    ) crc7 (
        .clk     (clk),
        .rst_    (rst_),
        .clear   (state != stSend),
        .enable  (crcEn),
        .din     (txReg[`FRAME_BITS-1]),
        .crc     (),
        .crcNext (crcNext)
    );

    // =========================================================================
    // Card state and response sequencing
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state     <= stIdle;
            acmd      <= 1'b0;
            writeMode <= 1'b0;
            cmdOe     <= 1'b0;
            respDone  <= 1'b0;
            txCnt     <= '0;
            delayCnt  <= '0;
        end else begin
            respDone <= 1'b0;
            if (cmdValid && accept) begin
                acmd <= (cmd.index == `CMD_55);
                if (cmd.index == `CMD_25) begin
                    writeMode <= 1'b1;
                end else if (cmd.index == `CMD_12) begin
                    writeMode <= 1'b0;
                end
            end
            case (state)
                stIdle: begin
                    if (start) begin
                        state    <= stDelay;
                        delayCnt <= DelayW'(`RESP_DELAY - 2);
                    end
                end
                stDelay: begin
                    if (delayCnt == '0) begin
                        state <= stSend;
                        cmdOe <= 1'b1;
                        txCnt <= '0;
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                stSend: begin
                    if (txCnt == 6'(`FRAME_BITS - 1)) begin
                        state    <= stIdle;
                        cmdOe    <= 1'b0;
                        respDone <= 1'b1;
                    end else begin
                        txCnt <= txCnt + 6'd1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Frame register, CRC and end bit replace the tail after bit 39
    always_ff @(posedge clk) begin
        if (start) begin
            txReg    <= {2'b00, resp.index, resp.arg, 7'h00, 1'b1};
            noCrcReg <= resp.noCrc;
        end else if (state == stSend) begin
            if (txCnt == 6'(CrcStart - 1)) begin
                txReg <= {crcField, 1'b1, {CrcStart{1'b0}}};
            end else begin
                txReg <= {txReg[`FRAME_BITS-2:0], 1'b1};
            end
        end
    end

    // Host must wait for the response before the next command
    assert property (@(posedge clk) disable iff (!rst_) cmdValid |-> state == stIdle);

endmodule

`default_nettype wire

//--- design/writeReceiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdCard_consts.svh"

module writeReceiver (
    input  wire                      clk,
    input  wire                      rst_,
    input  wire sdCardPkg::datNibbleT datIn,
    input  wire                      writeMode,
    input  wire                      respDone,
    output sdCardPkg::datNibbleT     datOut,
    output logic [3:0]               datOe
);

    import sdCardPkg::*;

    localparam int CntW     = $clog2(`BLOCK_NIBBLES);
    localparam int SendBits = 5 + `BUSY_CYCLES + 1;

    typedef enum logic [2:0] {
        stIdle, stData, stCrc, stEnd, stGap, stToken, stBusy
    } stateT;

    stateT                state;
    logic                 armed;
    logic [CntW-1:0]      cnt;
    crc16T                laneCrc [4];
    crc16T                rxCrc [4];
    logic [3:0]           laneOk;
    logic [SendBits-1:0]  sendSr;
    logic                 oe;

    // =========================================================================
    // Per-lane CRC16
    // =========================================================================
    for (genvar lane = 0; lane < 4; lane++) begin : gLane
        serialCrc #(
            .crcT (crc16T),
            .poly (`CRC16_POLY)
        ) crc16 (
            .clk     (clk),
            .rst_    (rst_),
            .clear   (state == stIdle),
            .enable  (state == stData),
            .din     (datIn[lane]),
            .crc     (laneCrc[lane]),
            .crcNext ()
        );

        always_ff @(posedge clk) begin
            if (state == stCrc) begin
                rxCrc[lane] <= {rxCrc[lane][14:0], datIn[lane]};
            end
        end

        // Valid while the end bit is on the line
        assign laneOk[lane] = (laneCrc[lane] == rxCrc[lane]) && datIn[lane];
    end

    // =========================================================================
    // Block FSM
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state <= stIdle;
            armed <= 1'b0;
            oe    <= 1'b0;
            cnt   <= '0;
        end else if (!writeMode) begin
            // Stop command ends the transfer wherever it is
            state <= stIdle;
            armed <= 1'b0;
            oe    <= 1'b0;
        end else begin
            if (respDone) begin
                armed <= 1'b1;
            end
            case (state)
                stIdle: begin
                    if (armed && !datIn[0]) begin
                        state <= stData;
                        cnt   <= CntW'(`BLOCK_NIBBLES - 1);
                    end
                end
                stData: begin
                    if (cnt == '0) begin
                        state <= stCrc;
                        cnt   <= CntW'($bits(crc16T) - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                stCrc: begin
                    if (cnt == '0) begin
                        state <= stEnd;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                stEnd: begin
                    state <= stGap;
                    cnt   <= CntW'(`TOKEN_GAP - 1);
                end
                stGap: begin
                    if (cnt == '0) begin
                        state <= stToken;
                        oe    <= 1'b1;
                        cnt   <= CntW'(4);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                stToken: begin
                    if (cnt == '0) begin
                        state <= stBusy;
                        cnt   <= CntW'(`BUSY_CYCLES);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                stBusy: begin
                    if (cnt == '0) begin
                        state <= stIdle;
                        oe    <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Token, busy low, then release high
    always_ff @(posedge clk) begin
        if (state == stEnd) begin
            sendSr <= {(&laneOk) ? `TOKEN_OK : `TOKEN_BAD, {`BUSY_CYCLES{1'b0}}, 1'b1};
        end else if (state == stToken || state == stBusy) begin
            sendSr <= {sendSr[SendBits-2:0], 1'b1};
        end
    end

    assign datOut = {3'b111, sendSr[SendBits-1]};
    assign datOe  = {3'b000, oe};

    // Only DAT0 is ever driven, and only within a write
    assert property (@(posedge clk) disable iff (!rst_)
        datOe != 4'b0000 |-> datOe == 4'b0001 && $past(writeMode));

endmodule

`default_nettype wire

//--- design/sdCardEmu.sv
`timescale 1ns/1ps
`default_nettype none

module sdCardEmu (
    input  wire                       clk,
    input  wire                       rst_,
    input  wire                       cmdIn,
    output logic                      cmdOut,
    output logic                      cmdOe,
    input  wire sdCardPkg::datNibbleT datIn,
    output sdCardPkg::datNibbleT      datOut,
    output logic [3:0]                datOe
);

    import sdCardPkg::*;

    logic   cmdValid;
    sdCmdT  cmd;
    logic   writeMode;
    logic   respDone;

    cmdReceiver cmdRx (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdValid (cmdValid),
        .cmd      (cmd)
    );

    cmdResponder cmdResp (
        .clk       (clk),
        .rst_      (rst_),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .cmdOut    (cmdOut),
        .cmdOe     (cmdOe),
        .writeMode (writeMode),
        .respDone  (respDone)
    );

    writeReceiver wrRx (
        .clk       (clk),
        .rst_      (rst_),
        .datIn     (datIn),
        .writeMode (writeMode),
        .respDone  (respDone),
        .datOut    (datOut),
        .datOe     (datOe)
    );

endmodule

`default_nettype wire

//--- dv/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 40
) (
    output logic clk
);

    // Free-running SD clock
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PeriodNs / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- dv/sdCardTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdCard_consts.svh"

module sdCardTb;

    import sdCardPkg::*;

    localparam int MaxTests    = 32;
    localparam int RespWindow  = `RESP_DELAY + `FRAME_BITS + 8;
    localparam int TokenBits   = 5 + `BUSY_CYCLES + 1;
    localparam int TokenWindow = `TOKEN_GAP + TokenBits + 3;
    localparam logic [4:0] TokenGood   = 5'b00101;
    localparam logic [4:0] TokenCrcErr = 5'b01011;

    logic       clk;
    logic       rst_;
    logic       cmdIn;
    logic       cmdOut;
    logic       cmdOe;
    datNibbleT  datIn;
    datNibbleT  datOut;
    logic [3:0] datOe;

    // Test table, one entry per data file line
    string       tName [MaxTests];
    cmdIndexT    tIdx [MaxTests];
    logic [31:0] tArg [MaxTests];
    int          tBadCrc [MaxTests];
    int          tBadEnd [MaxTests];
    int          tExpResp [MaxTests];
    cmdIndexT    tExpIdx [MaxTests];
    logic [31:0] tExpArg [MaxTests];
    int          tBlocks [MaxTests];
    int          tCorrupt [MaxTests];

    int          numTests;
    int          errors;
    int          checks;
    int          budget;
    logic        budgetReady = 1'b0;
    logic        writeActive;
    datNibbleT   payload [`BLOCK_NIBBLES];

    tbClock clkGen (
        .clk (clk)
    );

    sdCardEmu dut0 (
        .clk    (clk),
        .rst_   (rst_),
        .cmdIn  (cmdIn),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe),
        .datIn  (datIn),
        .datOut (datOut),
        .datOe  (datOe)
    );

    // =========================================================================
    // Reference CRCs, MSB first, zero start value
    // =========================================================================
    function automatic crc7T crc7Of(input logic [39:0] bits);
        crc7T c;
        logic fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[39] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? `CRC7_POLY : 7'h00);
            bits = bits << 1;
        end
        return c;
    endfunction

    function automatic crc16T crc16Next(input crc16T c, input logic b);
        logic fb;
        fb = b ^ c[15];
        return {c[14:0], 1'b0} ^ (fb ? `CRC16_POLY : 16'h0000);
    endfunction

    // =========================================================================
    // Checks
    // =========================================================================
    task automatic compareValue(input string testName, input string what,
                                input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH test=%s field=%s expected=%0h actual=%0h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic requireTrue(input string testName, input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR test=%s: %s", testName, what);
        end
    endtask

    task automatic loadTests();
        int          fd;
        int          fields;
        string       line;
        string       name;
        cmdIndexT    idx;
        logic [31:0] arg;
        cmdIndexT    expIdx;
        logic [31:0] expArg;
        int          badCrc;
        int          badEnd;
        int          expResp;
        int          blocks;
        int          corrupt;
        fd = $fopen("dv/sdCardEmu_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: could not open dv/sdCardEmu_testdata.txt");
            return;
        end
        while (!$feof(fd) && numTests < MaxTests) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %h %d %d %d %h %h %d %d", name, idx, arg,
                                 badCrc, badEnd, expResp, expIdx, expArg, blocks, corrupt);
                if (fields == 10) begin
                    tName[numTests]    = name;
                    tIdx[numTests]     = idx;
                    tArg[numTests]     = arg;
                    tBadCrc[numTests]  = badCrc;
                    tBadEnd[numTests]  = badEnd;
                    tExpResp[numTests] = expResp;
                    tExpIdx[numTests]  = expIdx;
                    tExpArg[numTests]  = expArg;
                    tBlocks[numTests]  = blocks;
                    tCorrupt[numTests] = corrupt;
                    numTests++;
                end
            end
        end
        $fclose(fd);
    endtask

    // =========================================================================
    // CMD line
    // =========================================================================
    task automatic sendCommand(input int t);
        logic [39:0]            head;
        logic [`FRAME_BITS-1:0] frame;
        crc7T                   crc;
        head = {2'b01, tIdx[t], tArg[t]};
        crc  = crc7Of(head);
        if (tBadCrc[t] != 0) begin
            crc = crc ^ 7'h01;
        end
        frame = {head, crc, (tBadEnd[t] == 0)};
        for (int b = 0; b < `FRAME_BITS; b++) begin
            @(negedge clk);
            cmdIn = frame[`FRAME_BITS-1];
            frame = frame << 1;
        end
    endtask

    // Cycle 0 is the first falling edge after the end bit was sampled
    task automatic watchResponse(input int t);
        int                     riseAt;
        int                     highCnt;
        logic [39:0]            head;
        crc7T                   crcField;
        logic [`FRAME_BITS-1:0] got;
        logic [`FRAME_BITS-1:0] expected;
        riseAt   = -1;
        highCnt  = 0;
        got      = '0;
        head     = {2'b00, tExpIdx[t], tExpArg[t]};
        // R3 carries all ones instead of a CRC
        crcField = (tExpIdx[t] == `R3_INDEX) ? 7'h7F : crc7Of(head);
        expected = {head, crcField, 1'b1};
        for (int n = 0; n < RespWindow; n++) begin
            @(negedge clk);
            cmdIn = 1'b1;
            if (cmdOe) begin
                if (riseAt < 0) begin
                    riseAt = n;
                end
                got = {got[`FRAME_BITS-2:0], cmdOut};
                highCnt++;
            end
        end
        if (tExpResp[t] != 0) begin
            compareValue(tName[t], "responseDelay", 64'(`RESP_DELAY), 64'(riseAt));
            compareValue(tName[t], "responseLength", 64'(`FRAME_BITS), 64'(highCnt));
            compareValue(tName[t], "responseFrame", 64'(expected), 64'(got));
        end else begin
            requireTrue(tName[t], highCnt == 0, "cmdOe went high but no response was due");
        end
    endtask

    // =========================================================================
    // DAT lines, one write block
    // =========================================================================
    task automatic sendBlock(input int t, input int blockNo, input logic corrupt);
        crc16T                laneCrc [4];
        datNibbleT            nib;
        int                   flipPos;
        int                   flipLane;
        int                   riseAt;
        int                   highCnt;
        int                   earlyOe;
        int                   wrongLanes;
        logic [TokenBits-1:0] got;
        logic [TokenBits-1:0] expected;
        string                blkName;
        blkName    = $sformatf("%s/block%0d", tName[t], blockNo);
        riseAt     = -1;
        highCnt    = 0;
        earlyOe    = 0;
        wrongLanes = 0;
        got        = '0;
        flipPos    = int'($urandom % `BLOCK_NIBBLES);
        flipLane   = int'($urandom % 4);
        for (int l = 0; l < 4; l++) begin
            laneCrc[l] = '0;
        end
        for (int i = 0; i < `BLOCK_NIBBLES; i++) begin
            payload[i] = datNibbleT'($urandom);
            laneCrc[0] = crc16Next(laneCrc[0], payload[i][0]);
            laneCrc[1] = crc16Next(laneCrc[1], payload[i][1]);
            laneCrc[2] = crc16Next(laneCrc[2], payload[i][2]);
            laneCrc[3] = crc16Next(laneCrc[3], payload[i][3]);
        end

        // Start bit on all lanes, then data
        @(negedge clk);
        datIn = 4'h0;
        for (int i = 0; i < `BLOCK_NIBBLES; i++) begin
            @(negedge clk);
            nib = payload[i];
            if (corrupt && i == flipPos) begin
                nib = nib ^ datNibbleT'(4'b0001 << flipLane);
            end
            datIn = nib;
            if (datOe != 4'b0000) begin
                earlyOe++;
            end
        end
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            datIn = {laneCrc[3][15], laneCrc[2][15], laneCrc[1][15], laneCrc[0][15]};
            for (int l = 0; l < 4; l++) begin
                laneCrc[l] = laneCrc[l] << 1;
            end
        end
        @(negedge clk);
        datIn = 4'hF;

        // Token and busy window
        for (int n = 0; n < TokenWindow; n++) begin
            @(negedge clk);
            if (datOe != 4'b0000) begin
                if (riseAt < 0) begin
                    riseAt = n;
                end
                if (datOe != 4'b0001) begin
                    wrongLanes++;
                end
                got = {got[TokenBits-2:0], datOut[0]};
                highCnt++;
            end
        end

        requireTrue(blkName, earlyOe == 0, "card drove DAT while the host was sending");
        if (writeActive) begin
            expected = {(corrupt ? TokenCrcErr : TokenGood), {`BUSY_CYCLES{1'b0}}, 1'b1};
            compareValue(blkName, "tokenDelay", 64'(`TOKEN_GAP), 64'(riseAt));
            compareValue(blkName, "tokenLength", 64'(TokenBits), 64'(highCnt));
            compareValue(blkName, "tokenAndBusy", 64'(expected), 64'(got));
            requireTrue(blkName, wrongLanes == 0, "card drove a DAT lane other than DAT0");
        end else begin
            requireTrue(blkName, highCnt == 0, "token sent although no write was active");
        end
    endtask

    // =========================================================================
    // Watchdog
    // =========================================================================
    initial begin
        wait (budgetReady);
        repeat (budget) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish", budget);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("TEST FAIL");
        $finish;
    end

    // =========================================================================
    // Main sequence
    // =========================================================================
    initial begin
        void'($urandom(32'h7008));
        errors      = 0;
        checks      = 0;
        numTests    = 0;
        writeActive = 1'b0;
        rst_        = 1'b0;
        cmdIn       = 1'b1;
        datIn       = 4'hF;

        loadTests();
        budget = 500;
        for (int t = 0; t < numTests; t++) begin
            budget += `FRAME_BITS + RespWindow
                    + tBlocks[t] * (`BLOCK_NIBBLES + 18 + TokenWindow);
        end
        budgetReady = 1'b1;

        repeat (8) @(negedge clk);
        rst_ = 1'b1;
        repeat (4) @(negedge clk);
        requireTrue("reset", numTests > 0, "no tests were read from the data file");
        compareValue("reset", "cmdOe", 64'(0), 64'(cmdOe));
        compareValue("reset", "datOe", 64'(0), 64'(datOe));

        for (int t = 0; t < numTests; t++) begin
            sendCommand(t);
            watchResponse(t);
            // Write mode follows the CMD25 and CMD12 responses
            if (tExpResp[t] != 0 && tIdx[t] == `CMD_25) begin
                writeActive = 1'b1;
            end else if (tExpResp[t] != 0 && tIdx[t] == `CMD_12) begin
                writeActive = 1'b0;
            end
            for (int b = 1; b <= tBlocks[t]; b++) begin
                sendBlock(t, b, b == tCorrupt[t]);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/sdCardEmu_testdata.txt
# name index(hex) arg(hex) badCrc badEnd expResp expIndex(hex) expArg(hex) blocks corrupt
# corrupt is the 1-based block with a flipped data bit, 0 keeps every block intact
goIdle          00 00000000 0 0 0 00 00000000 0 0
sendIfCond      08 000001AA 0 0 1 08 000001AA 0 0
ifCondBadCrc    08 000001AA 1 0 0 00 00000000 0 0
relAddr         03 00000000 0 0 1 03 AAAA0520 0 0
relAddrBadEnd   03 00000000 0 1 0 00 00000000 0 0
selectWrongRca  07 12340000 0 0 0 00 00000000 0 0
selectCard      07 AAAA0000 0 0 1 07 00000700 0 0
unknownCmd      05 00000000 0 0 0 00 00000000 0 0
opCondNoApp     29 40FF8000 0 0 0 00 00000000 0 0
appCmd          37 AAAA0000 0 0 1 37 00000120 0 0
opCond          29 40FF8000 0 0 1 3F C1FF8080 0 0
appCmdZero      37 AAAA0000 0 0 1 37 00000120 0 0
setBlkZero      17 00000000 0 0 0 00 00000000 0 0
appCmdCount     37 AAAA0000 0 0 1 37 00000120 0 0
setBlkCount     17 00000004 0 0 1 17 00000900 0 0
writeMulti      19 00000000 0 0 1 19 00000900 4 3
stopTrans       0C 00000000 0 0 1 0C 00000900 1 0
ifCondAfter     08 00000155 0 0 1 08 00000155 0 0

//--- sdCardEmu.f
+incdir+design
design/sdCardPkg.sv
design/serialCrc.sv
design/cmdReceiver.sv
design/cmdResponder.sv
design/writeReceiver.sv
design/sdCardEmu.sv
dv/tbClock.sv
dv/sdCardTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sdCardTb -f sdCardEmu.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Build or simulation step failed"

[ -f sim.log ] && cat sim.log
grep -qx "TEST PASS" sim.log && exit 0 || exit 1
